// ==== common/soc_pkg.sv ====
package soc_pkg;

    // address map, byte addresses on the 64-bit bus
    localparam logic [63:0] ROM_BASE     = 64'h0000_0000_0000_0000;
    localparam logic [63:0] ROM_SIZE     = 64'h0000_0000_0000_1000;
    localparam logic [63:0] RAM_BASE     = 64'h0000_0000_0000_1000;
    localparam logic [63:0] RAM_SIZE     = 64'h0000_0000_0000_1000;

    // single-word peripheral registers
    localparam logic [63:0] KEY_ADDR     = 64'h0000_0000_0000_FFFE;
    localparam logic [63:0] CONSOLE_ADDR = 64'h0000_0000_0000_FFFF;

    // shared memory, rom words first then ram words
    localparam int MEM_WORDS   = 2048;
    localparam int MEM_INDEX_W = 11;

    // returned for anything that is not readable
    localparam logic [63:0] UNMAPPED_DATA = 64'hDEAD_BEEF_DEAD_BEEF;

    // vector presented to the core on a key press
    localparam logic [3:0] IRQ_KEYBOARD = 4'd1;

    // ps/2 framing: start, 8 data, odd parity, stop
    localparam int         PS2_FRAME_BITS = 11;
    localparam logic [7:0] PS2_BREAK_CODE = 8'hF0;

    // decoded target of one bus access
    typedef enum logic [2:0] {
        REGION_ROM,
        REGION_RAM,
        REGION_KEY,
        REGION_CONSOLE,
        REGION_NONE
    } region_t;

    // cpu data bus request, we and re are one-cycle strobes
    typedef struct packed {
        logic [63:0] addr;
        logic [63:0] wdata;
        logic        we;
        logic        re;
    } bus_req_t;

    // read response, valid for one cycle
    typedef struct packed {
        logic [63:0] rdata;
        logic        valid;
    } bus_rsp_t;

    // data-port request into the shared memory
    typedef struct packed {
        logic [MEM_INDEX_W-1:0] index;
        logic [31:0]            wdata;
        logic                   we;
        logic                   re;
    } mem_req_t;

    // one decoded keyboard event
    typedef struct packed {
        logic [7:0] scan;
        logic [7:0] ascii;
        logic       pressed;
        logic       released;
    } key_event_t;

endpackage

// ==== hw/unified_mem.sv ====
`timescale 1ns/10ps

module unified_mem import soc_pkg::*; (
    input  logic        CLOCK_50,
    // data side from bus control
    input  mem_req_t    mem_req,
    output logic [31:0] mem_rdata,
    // instruction side
    input  logic [31:0] fetch_pc,
    output logic [31:0] instruction
);

    // words 0..1023 are the boot rom, 1024..2047 the ram
    logic [31:0] mem [0:MEM_WORDS-1];

    // raw fetched word before the swap
    logic [31:0] fetch_word;

    // fetch index, bits 12:2 of the pc
    logic [MEM_INDEX_W-1:0] fetch_index;

    // no image is loaded, so everything starts out zero
    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = 32'd0;
        end
    end

    // data port write
    // the bus never raises we and re in the same cycle
    always_ff @(posedge CLOCK_50) begin
        if (mem_req.we)
            mem[mem_req.index] <= mem_req.wdata;
    end

    // data port read, holds the last word between reads
    always_ff @(posedge CLOCK_50) begin
        if (mem_req.re)
            mem_rdata <= mem[mem_req.index];
    end

    assign fetch_index = fetch_pc[MEM_INDEX_W+1:2];

    // fetch port reads every cycle
    always_ff @(posedge CLOCK_50) begin
        fetch_word <= mem[fetch_index];
    end

    // images are stored big-endian
    // the core wants little-endian instruction words
    assign instruction = {
        fetch_word[7:0],
        fetch_word[15:8],
        fetch_word[23:16],
        fetch_word[31:24]
    };

endmodule

// ==== hw/bus_control.sv ====
`timescale 1ns/10ps

module bus_control import soc_pkg::*; (
    input  logic        CLOCK_50,
    input  logic        KEY0,
    input  bus_req_t    bus_req,
    output bus_rsp_t    bus_rsp,
    output mem_req_t    mem_req,
    input  logic [31:0] mem_rdata,
    input  key_event_t  key_event,
    output logic [7:0]  console_byte,
    output logic        console_strobe
);

    // decode of the current request
    region_t     region;

    // read pipeline, stage 1 follows the sampling edge
    logic        rd_valid_q1;
    region_t     rd_region_q1;
    // stage 2 holds the memory word as well
    logic        rd_valid_q2;
    region_t     rd_region_q2;
    logic [31:0] rd_word_q2;

    // response register and its next value
    logic        rsp_valid;
    logic [63:0] rsp_rdata;
    logic [63:0] rsp_next;

    // last ascii byte typed
    logic [7:0]  key_byte;

    // address map decode
    // subtract then compare, so the range check wraps cleanly
    always_comb begin
        if ((bus_req.addr - ROM_BASE) < ROM_SIZE)
            region = REGION_ROM;
        else if ((bus_req.addr - RAM_BASE) < RAM_SIZE)
            region = REGION_RAM;
        else if (bus_req.addr == KEY_ADDR)
            region = REGION_KEY;
        else if (bus_req.addr == CONSOLE_ADDR)
            region = REGION_CONSOLE;
        else
            region = REGION_NONE;
    end

    // word index is addr[12:2], ram sits in the upper half
    always_comb begin
        mem_req.index = bus_req.addr[MEM_INDEX_W+1:2];
        mem_req.wdata = bus_req.wdata[31:0];
        // rom is read-only, writes there just vanish
        mem_req.we    = bus_req.we && (region == REGION_RAM);
        mem_req.re    = bus_req.re && (region == REGION_ROM || region == REGION_RAM);
    end

    // region travels with each read so responses stay in order
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            rd_valid_q1  <= 1'b0;
            rd_region_q1 <= REGION_NONE;
            rd_valid_q2  <= 1'b0;
            rd_region_q2 <= REGION_NONE;
        end else begin
            rd_valid_q1  <= bus_req.re;
            rd_region_q1 <= region;
            rd_valid_q2  <= rd_valid_q1;
            rd_region_q2 <= rd_region_q1;
        end
    end

    // memory answers one cycle after re
    always_ff @(posedge CLOCK_50) begin
        rd_word_q2 <= mem_rdata;
    end

    // response data select
    always_comb begin
        case (rd_region_q2)
            REGION_ROM,
            REGION_RAM: rsp_next = {32'd0, rd_word_q2};
            REGION_KEY: rsp_next = {56'd0, key_byte};
            default:    rsp_next = UNMAPPED_DATA;
        endcase
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0)
            rsp_valid <= 1'b0;
        else
            rsp_valid <= rd_valid_q2;
    end

    always_ff @(posedge CLOCK_50) begin
        rsp_rdata <= rsp_next;
    end

    assign bus_rsp.rdata = rsp_rdata;
    assign bus_rsp.valid = rsp_valid;

    // keys without ascii leave the last byte alone
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0)
            key_byte <= 8'd0;
        else if (key_event.pressed && key_event.ascii != 8'd0)
            key_byte <= key_event.ascii;
    end

    // console write, one strobe per write
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0)
            console_strobe <= 1'b0;
        else
            console_strobe <= bus_req.we && (region == REGION_CONSOLE);
    end

    always_ff @(posedge CLOCK_50) begin
        if (bus_req.we && region == REGION_CONSOLE)
            console_byte <= bus_req.wdata[7:0];
    end

endmodule

// ==== keyboard/ps2_receiver.sv ====
`timescale 1ns/10ps

module ps2_receiver import soc_pkg::*; (
    input  logic       CLOCK_50,
    input  logic       KEY0,
    input  logic       ps2_clk,
    input  logic       ps2_dat,
    output key_event_t key_event
);

    // two-flop synchronizers, idle line is high
    logic [1:0]  clk_sync;
    logic [1:0]  dat_sync;
    logic        clk_prev;
    logic        clk_fall;

    // frame shifter, lsb arrives first
    logic [10:0] frame;
    logic [3:0]  bit_cnt;
    logic        frame_done;

    // decoded fields of a full frame
    logic [7:0]  frame_code;
    logic        frame_ok;

    // f0 seen, next code is a break
    logic        break_pending;

    // event registers
    logic        ev_pressed;
    logic        ev_released;
    logic [7:0]  ev_scan;
    logic [7:0]  ev_ascii;

    // scan set 2 to lower-case ascii, letters and digits only
    function automatic logic [7:0] scan_to_ascii(input logic [7:0] code);
        logic [7:0] ch;
        ch = 8'h00;
        case (code)
            8'h1C: ch = "a";
            8'h32: ch = "b";
            8'h21: ch = "c";
            8'h23: ch = "d";
            8'h24: ch = "e";
            8'h2B: ch = "f";
            8'h34: ch = "g";
            8'h33: ch = "h";
            8'h43: ch = "i";
            8'h3B: ch = "j";
            8'h42: ch = "k";
            8'h4B: ch = "l";
            8'h3A: ch = "m";
            8'h31: ch = "n";
            8'h44: ch = "o";
            8'h4D: ch = "p";
            8'h15: ch = "q";
            8'h2D: ch = "r";
            8'h1B: ch = "s";
            8'h2C: ch = "t";
            8'h3C: ch = "u";
            8'h2A: ch = "v";
            8'h1D: ch = "w";
            8'h22: ch = "x";
            8'h35: ch = "y";
            8'h1A: ch = "z";
            8'h45: ch = "0";
            8'h16: ch = "1";
            8'h1E: ch = "2";
            8'h26: ch = "3";
            8'h25: ch = "4";
            8'h2E: ch = "5";
            8'h36: ch = "6";
            8'h3D: ch = "7";
            8'h3E: ch = "8";
            8'h46: ch = "9";
            default: ch = 8'h00;
        endcase
        return ch;
    endfunction

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            clk_sync <= 2'b11;
            dat_sync <= 2'b11;
            clk_prev <= 1'b1;
        end else begin
            clk_sync <= {clk_sync[0], ps2_clk};
            dat_sync <= {dat_sync[0], ps2_dat};
            clk_prev <= clk_sync[1];
        end
    end

    // keyboard drives data, we sample on its falling clock
    assign clk_fall = clk_prev && !clk_sync[1];

    // bit counter and frame-complete pulse
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            bit_cnt    <= 4'd0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            if (clk_fall) begin
                if (bit_cnt == 4'(PS2_FRAME_BITS - 1)) begin
                    bit_cnt    <= 4'd0;
                    frame_done <= 1'b1;
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end
        end
    end

    // shift right, so after 11 bits frame[0] is the start bit
    always_ff @(posedge CLOCK_50) begin
        if (clk_fall)
            frame <= {dat_sync[1], frame[10:1]};
    end

    assign frame_code = frame[8:1];
    // start low, stop high, odd parity over data plus parity bit
    assign frame_ok   = !frame[0] && frame[10] && (^frame[9:1]);

    // make/break tracking
    // bad frames just fall through here without an event
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            break_pending <= 1'b0;
            ev_pressed    <= 1'b0;
            ev_released   <= 1'b0;
        end else begin
            ev_pressed  <= 1'b0;
            ev_released <= 1'b0;
            if (frame_done && frame_ok) begin
                if (frame_code == PS2_BREAK_CODE) begin
                    break_pending <= 1'b1;
                end else if (break_pending) begin
                    break_pending <= 1'b0;
                    ev_released   <= 1'b1;
                end else begin
                    ev_pressed <= 1'b1;
                end
            end
        end
    end

    // code and ascii for both makes and breaks
    always_ff @(posedge CLOCK_50) begin
        if (frame_done && frame_ok && frame_code != PS2_BREAK_CODE) begin
            ev_scan  <= frame_code;
            ev_ascii <= scan_to_ascii(frame_code);
        end
    end

    assign key_event.scan     = ev_scan;
    assign key_event.ascii    = ev_ascii;
    assign key_event.pressed  = ev_pressed;
    assign key_event.released = ev_released;

endmodule

// ==== hw/irq_controller.sv ====
`timescale 1ns/10ps

module irq_controller import soc_pkg::*; (
    input  logic       CLOCK_50,
    input  logic       KEY0,
    input  key_event_t key_event,
    input  logic       irq_ack,
    output logic [3:0] irq_vector,
    output logic       irq_led
);

    // a press only counts when it maps to a character
    logic key_hit;

    // core has taken the pending vector
    logic ack_hit;

    assign key_hit = key_event.pressed && (key_event.ascii != 8'd0);
    assign ack_hit = irq_ack && (irq_vector != 4'd0);

    // vector held until acknowledged, so it is seen once
    // ack beats a new press in the same cycle
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            irq_vector <= 4'd0;
            irq_led    <= 1'b0;
        end else if (ack_hit) begin
            irq_vector <= 4'd0;
            irq_led    <= 1'b0;
        end else if (key_hit) begin
            irq_vector <= IRQ_KEYBOARD;
            // led mirrors the pending state
            irq_led    <= 1'b1;
        end
    end

endmodule

// ==== hw/soc_board.sv ====
`timescale 1ns/10ps

module soc_board import soc_pkg::*; (
    input  logic        CLOCK_50,
    input  logic        KEY0,
    // cpu data bus
    input  bus_req_t    bus_req,
    output bus_rsp_t    bus_rsp,
    // cpu instruction fetch
    input  logic [31:0] fetch_pc,
    output logic [31:0] instruction,
    // ps/2 keyboard pins
    input  logic        ps2_clk,
    input  logic        ps2_dat,
    // interrupt to the core
    output logic [3:0]  irq_vector,
    input  logic        irq_ack,
    output logic        irq_led,
    // console output in place of the uart
    output logic [7:0]  console_byte,
    output logic        console_strobe
);

    // bus control to memory data port
    mem_req_t    mem_req;
    logic [31:0] mem_rdata;

    // keyboard events, shared by bus and irq side
    key_event_t  key_event;

    // decode, read pipeline, key latch, console
    bus_control u_bus_control (
        .CLOCK_50       (CLOCK_50),
        .KEY0           (KEY0),
        .bus_req        (bus_req),
        .bus_rsp        (bus_rsp),
        .mem_req        (mem_req),
        .mem_rdata      (mem_rdata),
        .key_event      (key_event),
        .console_byte   (console_byte),
        .console_strobe (console_strobe)
    );

    // one array behind both fetch and data ports
    unified_mem u_unified_mem (
        .CLOCK_50    (CLOCK_50),
        .mem_req     (mem_req),
        .mem_rdata   (mem_rdata),
        .fetch_pc    (fetch_pc),
        .instruction (instruction)
    );

    // keyboard frames to make/break events
    ps2_receiver u_ps2_receiver (
        .CLOCK_50  (CLOCK_50),
        .KEY0      (KEY0),
        .ps2_clk   (ps2_clk),
        .ps2_dat   (ps2_dat),
        .key_event (key_event)
    );

    // pending keyboard vector
    irq_controller u_irq_controller (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .key_event  (key_event),
        .irq_ack    (irq_ack),
        .irq_vector (irq_vector),
        .irq_led    (irq_led)
    );

endmodule

// ==== tests/tb_soc_board.sv ====
`timescale 1ns/10ps

module tb_soc_board import soc_pkg::*; ();

    // 8 ns clock with inputs changing 1 ns after the rising edge
    localparam int RESET_CYCLES     = 8;
    localparam int DRIVE_DELAY      = 1;
    localparam int PS2_HALF_CYCLES  = 5;
    localparam int PS2_GAP_CYCLES   = 20;
    localparam int PS2_FRAME_CYCLES = 11 * 2 * PS2_HALF_CYCLES + PS2_GAP_CYCLES;
    localparam int PS2_FRAMES       = 5;
    localparam int BUS_OPS          = 80;
    localparam int BUS_OP_CYCLES    = 4;
    localparam int MARGIN_CYCLES    = 400;
    localparam int WATCHDOG_CYCLES  = RESET_CYCLES + BUS_OPS * BUS_OP_CYCLES
                                    + PS2_FRAMES * PS2_FRAME_CYCLES + MARGIN_CYCLES;
    localparam int WAIT_LIMIT       = 50;
    localparam logic [31:0] LFSR_SEED = 32'h449e_532e;

    logic        CLOCK_50 = 1'b0;
    logic        KEY0;
    bus_req_t    bus_req;
    bus_rsp_t    bus_rsp;
    logic [31:0] fetch_pc;
    logic [31:0] instruction;
    logic        ps2_clk;
    logic        ps2_dat;
    logic [3:0]  irq_vector;
    logic        irq_ack;
    logic        irq_led;
    logic [7:0]  console_byte;
    logic        console_strobe;

    // reference state
    logic [31:0] shadow [0:MEM_WORDS-1];
    logic [7:0]  exp_key;
    logic [31:0] lfsr;
    logic [63:0] exp_data[$];
    int          exp_cycle[$];
    logic [7:0]  exp_console[$];

    // bookkeeping
    int          cycle_cnt = 0;
    int          err_cnt = 0;
    int          check_cnt = 0;
    int          tests_run = 0;
    int          irq_sets = 0;
    int          console_pulses = 0;
    logic [3:0]  irq_prev = 4'd0;

    soc_board DUT (.*);

    always #4 CLOCK_50 = ~CLOCK_50;

    always @(posedge CLOCK_50) cycle_cnt <= cycle_cnt + 1;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // one lfsr step per bit taken
    task automatic take_bits(input int n, output logic [31:0] v);
        v = 32'd0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    // predicted read data straight from the address map
    function automatic logic [63:0] expected_read(input logic [63:0] addr);
        if (addr < RAM_BASE + RAM_SIZE)
            return {32'd0, shadow[addr[12:2]]};
        if (addr == KEY_ADDR)
            return {56'd0, exp_key};
        return UNMAPPED_DATA;
    endfunction

    // only ram keeps what is written
    function automatic void ref_write(input logic [63:0] addr, input logic [63:0] data);
        if (addr >= RAM_BASE && addr < RAM_BASE + RAM_SIZE)
            shadow[addr[12:2]] = data[31:0];
    endfunction

    // byte i of the result is byte 3-i of the word
    function automatic logic [31:0] byte_swap(input logic [31:0] w);
        logic [31:0] r;
        for (int i = 0; i < 4; i++)
            r[8*i +: 8] = w[8*(3-i) +: 8];
        return r;
    endfunction

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        check_cnt++;
        if (actual !== expected) begin
            $display("Mismatch %s: got 0x%h, expected 0x%h", name, actual, expected);
            err_cnt++;
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge CLOCK_50);
        #DRIVE_DELAY;
    endtask

    task automatic bus_write(input logic [63:0] addr, input logic [63:0] data);
        bus_req.addr  = addr;
        bus_req.wdata = data;
        bus_req.we    = 1'b1;
        ref_write(addr, data);
        if (addr == CONSOLE_ADDR)
            exp_console.push_back(data[7:0]);
        wait_cycles(1);
        bus_req.we = 1'b0;
    endtask

    // sampled on the next edge and answered two edges later
    task automatic bus_read(input logic [63:0] addr);
        bus_req.addr = addr;
        bus_req.re   = 1'b1;
        exp_data.push_back(expected_read(addr));
        exp_cycle.push_back(cycle_cnt + 3);
        wait_cycles(1);
        bus_req.re = 1'b0;
    endtask

    task automatic wait_responses();
        int waited;
        waited = 0;
        while (exp_data.size() != 0 && waited < WAIT_LIMIT) begin
            wait_cycles(1);
            waited++;
        end
        if (exp_data.size() != 0) begin
            $display("error: %0d read response(s) never arrived", exp_data.size());
            err_cnt++;
            exp_data.delete();
            exp_cycle.delete();
        end
    endtask

    // word comes back reversed one cycle after the pc is taken
    task automatic fetch_check(input logic [63:0] addr);
        logic [31:0] word;
        word = shadow[addr[12:2]];
        fetch_pc = addr[31:0];
        @(posedge CLOCK_50);
        @(negedge CLOCK_50);
        check_value("instruction", {32'd0, instruction}, {32'd0, byte_swap(word)});
        wait_cycles(1);
    endtask

    // start bit then 8 data bits lsb first then odd parity and stop
    task automatic send_ps2(input logic [7:0] code, input logic bad_parity);
        logic [10:0] bits;
        logic        parity;
        parity = ~(^code);
        if (bad_parity)
            parity = ~parity;
        bits = {1'b1, parity, code, 1'b0};
        for (int i = 0; i < 11; i++) begin
            ps2_dat = bits[i];
            wait_cycles(PS2_HALF_CYCLES);
            ps2_clk = 1'b0;
            wait_cycles(PS2_HALF_CYCLES);
            ps2_clk = 1'b1;
        end
        ps2_dat = 1'b1;
        wait_cycles(PS2_GAP_CYCLES);
    endtask

    task automatic wait_irq();
        int waited;
        waited = 0;
        while (irq_vector == 4'd0 && waited < WAIT_LIMIT) begin
            wait_cycles(1);
            waited++;
        end
        if (irq_vector == 4'd0) begin
            $display("error: keyboard interrupt never came after the key press");
            err_cnt++;
        end
    endtask

    task automatic report_test(input string name, input int start_err);
        tests_run++;
        if (err_cnt == start_err)
            $display("test %0d %s: ok", tests_run, name);
        else
            $display("test %0d %s: %0d error(s)", tests_run, name, err_cnt - start_err);
    endtask

    // responses, console strobes and irq edges all sampled mid-cycle
    always @(negedge CLOCK_50) begin
        if (KEY0 && bus_rsp.valid) begin
            if (exp_data.size() == 0) begin
                $display("error: read response arrived with no read outstanding");
                err_cnt++;
            end else begin
                check_value("bus_rsp.rdata", bus_rsp.rdata, exp_data.pop_front());
                check_value("bus_rsp.valid cycle", 64'(cycle_cnt), 64'(exp_cycle.pop_front()));
            end
        end
        if (KEY0 && console_strobe) begin
            console_pulses++;
            if (exp_console.size() == 0) begin
                $display("error: console strobe without a pending console write");
                err_cnt++;
            end else begin
                check_value("console_byte", {56'd0, console_byte},
                            {56'd0, exp_console.pop_front()});
            end
        end
        if (KEY0 && irq_vector != 4'd0 && irq_prev == 4'd0)
            irq_sets++;
        if (KEY0 && irq_led != (irq_vector != 4'd0)) begin
            $display("error: irq_led does not follow irq_vector");
            err_cnt++;
        end
        irq_prev = irq_vector;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge CLOCK_50);
        $display("error: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        logic [63:0] ram_addr [0:15];
        logic [63:0] addr;
        logic [31:0] offset;
        logic [31:0] lo;
        logic [31:0] hi;
        int          start_err;
        int          sets0;
        int          pulses0;
        KEY0     = 1'b0;
        bus_req  = '0;
        fetch_pc = 32'd0;
        ps2_clk  = 1'b1;
        ps2_dat  = 1'b1;
        irq_ack  = 1'b0;
        lfsr     = LFSR_SEED;
        exp_key  = 8'd0;
        for (int i = 0; i < MEM_WORDS; i++)
            shadow[i] = 32'd0;
        wait_cycles(RESET_CYCLES);
        KEY0 = 1'b1;
        wait_cycles(2);

        // random ram words then reads every cycle
        start_err = err_cnt;
        for (int i = 0; i < 16; i++) begin
            take_bits(10, offset);
            take_bits(32, lo);
            take_bits(32, hi);
            ram_addr[i] = RAM_BASE + {52'd0, offset[9:0], 2'b00};
            bus_write(ram_addr[i], {hi, lo});
        end
        for (int i = 0; i < 16; i++)
            bus_read(ram_addr[i]);
        wait_responses();
        report_test("ram write and read", start_err);

        // rom ignores writes and holes read as the unmapped pattern
        start_err = err_cnt;
        take_bits(32, lo);
        bus_write(64'h0100, {32'd0, lo});
        bus_write(ROM_BASE + ROM_SIZE - 64'd4, {lo, ~lo});
        bus_read(64'h0100);
        bus_read(ROM_BASE + ROM_SIZE - 64'd4);
        bus_read(64'h2000);
        bus_read(64'hFFF0);
        bus_read(64'h1_0000);
        bus_read(CONSOLE_ADDR);
        wait_responses();
        report_test("rom and unmapped reads", start_err);

        // fetch port sees bus writes byte-reversed
        start_err = err_cnt;
        for (int i = 0; i < 4; i++) begin
            take_bits(10, offset);
            take_bits(32, lo);
            addr = RAM_BASE + {52'd0, offset[9:0], 2'b00};
            bus_write(addr, {32'd0, lo});
            fetch_check(addr);
        end
        fetch_check(ram_addr[0]);
        fetch_check(64'h0100);
        report_test("instruction fetch", start_err);

        // letter a raises the vector once
        start_err = err_cnt;
        sets0 = irq_sets;
        send_ps2(8'h1C, 1'b0);
        wait_irq();
        check_value("irq_vector", {60'd0, irq_vector}, {60'd0, IRQ_KEYBOARD});
        check_value("irq_led", {63'd0, irq_led}, 64'd1);
        exp_key = "a";
        bus_read(KEY_ADDR);
        wait_responses();
        irq_ack = 1'b1;
        wait_cycles(1);
        irq_ack = 1'b0;
        check_value("irq_vector", {60'd0, irq_vector}, 64'd0);
        wait_cycles(40);
        check_value("irq_vector", {60'd0, irq_vector}, 64'd0);
        check_value("irq_led", {63'd0, irq_led}, 64'd0);
        check_value("irq set count", 64'(irq_sets - sets0), 64'd1);
        report_test("key press interrupt", start_err);

        // break of b then c with bad parity then escape without ascii
        start_err = err_cnt;
        sets0 = irq_sets;
        send_ps2(PS2_BREAK_CODE, 1'b0);
        send_ps2(8'h32, 1'b0);
        send_ps2(8'h21, 1'b1);
        send_ps2(8'h76, 1'b0);
        wait_cycles(10);
        check_value("irq_vector", {60'd0, irq_vector}, 64'd0);
        check_value("irq set count", 64'(irq_sets - sets0), 64'd0);
        bus_read(KEY_ADDR);
        wait_responses();
        report_test("ignored keyboard frames", start_err);

        // only console writes strobe
        start_err = err_cnt;
        pulses0 = console_pulses;
        take_bits(32, lo);
        bus_write(CONSOLE_ADDR, {32'hFFFF_FFFF, lo});
        bus_write(RAM_BASE + 64'd8, {32'd0, lo});
        bus_write(KEY_ADDR, {32'd0, lo});
        bus_write(64'h0200, {32'd0, lo});
        take_bits(32, lo);
        bus_write(CONSOLE_ADDR, {32'd0, lo});
        wait_cycles(4);
        check_value("console strobe count", 64'(console_pulses - pulses0), 64'd2);
        if (exp_console.size() != 0) begin
            $display("error: console write produced no strobe");
            err_cnt++;
        end
        bus_read(KEY_ADDR);
        bus_read(RAM_BASE + 64'd8);
        wait_responses();
        report_test("console output", start_err);

        $display("tests %0d, checks %0d, errors %0d", tests_run, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== build.f ====
common/soc_pkg.sv
hw/unified_mem.sv
hw/bus_control.sv
keyboard/ps2_receiver.sv
hw/irq_controller.sv
hw/soc_board.sv
tests/tb_soc_board.sv

// ==== Makefile ====
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
TOP        ?= tb_soc_board
FILELIST   ?= build.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
SOURCES    := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
